// File: Bender.yml
package:
  name: msk_alu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/msk_pkg.sv
      - rtl/msk_prng.sv
      - rtl/msk_shift_rotate.sv
      - rtl/msk_logic_ti.sv
      - rtl/msk_mask_unit.sv
      - rtl/msk_alu.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_msk_alu.sv

// File: rtl/msk_alu.sv
// Two-share masked ALU
`timescale 1ns/100ps
`include "msk_defs.svh"

module msk_alu (
  input  logic                     g_clk,
  input  logic                     g_resetn,
  input  logic                     i_valid,   // Single-cycle operation strobe
  input  msk_pkg::msk_op_t         i_op,
  input  msk_pkg::share_t          i_rs1_s0,
  input  msk_pkg::share_t          i_rs1_s1,
  input  msk_pkg::share_t          i_rs2_s0,
  input  msk_pkg::share_t          i_rs2_s1,
  input  logic [`MSK_SHAMT_W-1:0]  i_shamt,
  output logic                     o_valid,   // Result strobe, two edges after i_valid
  output msk_pkg::share_t          o_rd_s0,
  output msk_pkg::share_t          o_rd_s1
);

  import msk_pkg::*;

  share_t  prng;

  share_t  log_r0, log_r1;
  share_t  msk_r0, msk_r1;
  share_t  shf_s0, shf_s1;   // Combinational shifter outputs

  logic    v1_q, v2_q;
  msk_op_t op1_q, op2_q;
  share_t  shf0_q1, shf1_q1;
  share_t  shf0_q2, shf1_q2;

  logic    sel_logic;
  logic    sel_shift;
  logic    sel_mask;

  // The LFSR moves on every accept edge
  msk_prng prng_inst (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_step   (i_valid),
    .o_rand   (prng)
  );

  msk_logic_ti logic_inst (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_valid  (i_valid),
    .i_op     (i_op),
    .i_a0     (i_rs1_s0),
    .i_a1     (i_rs1_s1),
    .i_b0     (i_rs2_s0),
    .i_b1     (i_rs2_s1),
    .i_rand   (prng),
    .o_r0     (log_r0),
    .o_r1     (log_r1)
  );

  msk_mask_unit mask_inst (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_valid  (i_valid),
    .i_op     (i_op),
    .i_s0     (i_rs1_s0),
    .i_s1     (i_rs1_s1),
    .i_rand   (prng),
    .o_r0     (msk_r0),
    .o_r1     (msk_r1)
  );

  // One shifter per share, both padded from the same random word
  msk_shift_rotate shift0_inst (
    .i_share  (i_rs1_s0),
    .i_shamt  (i_shamt),
    .i_pad    (prng),
    .i_op     (i_op),
    .o_share  (shf_s0)
  );

  msk_shift_rotate shift1_inst (
    .i_share  (i_rs1_s1),
    .i_shamt  (i_shamt),
    .i_pad    (prng),
    .i_op     (i_op),
    .o_share  (shf_s1)
  );

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      v1_q    <= 1'b0;
      v2_q    <= 1'b0;
      op1_q   <= OP_NOT;
      op2_q   <= OP_NOT;
      shf0_q1 <= '0;
      shf1_q1 <= '0;
      shf0_q2 <= '0;
      shf1_q2 <= '0;
    end else begin
      v1_q <= i_valid;
      v2_q <= v1_q;
      if (i_valid) begin
        op1_q   <= i_op;
        shf0_q1 <= shf_s0;
        shf1_q1 <= shf_s1;
      end
      if (v1_q) begin
        op2_q   <= op1_q;
        shf0_q2 <= shf0_q1;   // Matches the two-stage units
        shf1_q2 <= shf1_q1;
      end
    end
  end

  // Result class of the operation now in stage 2
  assign sel_logic = v2_q && (op2_q inside {OP_NOT, OP_XOR, OP_AND, OP_IOR});
  assign sel_shift = v2_q && (op2_q inside {OP_SRLI, OP_SLLI, OP_RORI});
  assign sel_mask  = v2_q && (op2_q inside {OP_BMASK, OP_AMASK, OP_BREMASK, OP_AREMASK});

  // AND-OR select, at most one class is active
  assign o_rd_s0 = ({`MSK_XLEN{sel_logic}} & log_r0)  |
                   ({`MSK_XLEN{sel_shift}} & shf0_q2) |
                   ({`MSK_XLEN{sel_mask}}  & msk_r0);

  assign o_rd_s1 = ({`MSK_XLEN{sel_logic}} & log_r1)  |
                   ({`MSK_XLEN{sel_shift}} & shf1_q2) |
                   ({`MSK_XLEN{sel_mask}}  & msk_r1);

  assign o_valid = v2_q;

endmodule

// File: rtl/msk_defs.svh
// Masked ALU widths and seed
`ifndef MSK_DEFS_SVH
`define MSK_DEFS_SVH

// Width of one share word
`define MSK_XLEN 32

// Immediate shift amount, five barrel levels
`define MSK_SHAMT_W 5

// LFSR reset value, must not be the XNOR lock-up state
`define MSK_PRNG_SEED 32'h6789_abcd

`endif

// File: rtl/msk_logic_ti.sv
// Masked logic unit
`timescale 1ns/100ps
`include "msk_defs.svh"

module msk_logic_ti (
  input  logic              g_clk,
  input  logic              g_resetn,
  input  logic              i_valid,
  input  msk_pkg::msk_op_t  i_op,
  input  msk_pkg::share_t   i_a0,
  input  msk_pkg::share_t   i_a1,
  input  msk_pkg::share_t   i_b0,
  input  msk_pkg::share_t   i_b1,
  input  msk_pkg::share_t   i_rand,
  output msk_pkg::share_t   o_r0,
  output msk_pkg::share_t   o_r1
);

  import msk_pkg::*;

  logic    is_or;
  logic    load1;
  share_t  a1_in;
  share_t  b1_in;

  logic    v1_q;
  msk_op_t op_q;
  share_t  t0_q, t1_q, t2_q, t3_q;  // Cross products of the threshold AND
  share_t  lin0_q, lin1_q;         // XOR or NOT shares

  logic    nonlin;
  logic    inv1;

  assign is_or = (i_op == OP_IOR);
  assign load1 = i_valid && (i_op inside {OP_NOT, OP_XOR, OP_AND, OP_IOR});

  // De Morgan for OR, share 1 inverted flips the whole value
  assign a1_in = is_or ? ~i_a1 : i_a1;
  assign b1_in = is_or ? ~i_b1 : i_b1;

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      v1_q   <= 1'b0;
      op_q   <= OP_NOT;
      t0_q   <= '0;
      t1_q   <= '0;
      t2_q   <= '0;
      t3_q   <= '0;
      lin0_q <= '0;
      lin1_q <= '0;
    end else begin
      v1_q <= load1;
      if (load1) begin
        op_q   <= i_op;
        t0_q   <= i_rand ^ (i_a0 & i_b0);   // Fresh mask on share 0 side
        t1_q   <= i_rand ^ (i_a0 & b1_in);
        t2_q   <= a1_in & i_b0;
        t3_q   <= a1_in & b1_in;
        lin0_q <= (i_op == OP_NOT) ? i_a0 : (i_a0 ^ i_b0);
        lin1_q <= (i_op == OP_NOT) ? ~i_a1 : (i_a1 ^ i_b1);
      end
    end
  end

  assign nonlin = (op_q == OP_AND) || (op_q == OP_IOR);
  assign inv1   = (op_q == OP_IOR);

  // Partial products only meet after the stage 1 registers
  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      o_r0 <= '0;
      o_r1 <= '0;
    end else if (v1_q) begin
      o_r0 <= nonlin ? (t0_q ^ t2_q) : lin0_q;
      o_r1 <= nonlin ? (t1_q ^ t3_q ^ {`MSK_XLEN{inv1}}) : lin1_q;
    end
  end

endmodule

// File: rtl/msk_mask_unit.sv
// Mask and remask unit
`timescale 1ns/100ps

module msk_mask_unit (
  input  logic              g_clk,
  input  logic              g_resetn,
  input  logic              i_valid,
  input  msk_pkg::msk_op_t  i_op,
  input  msk_pkg::share_t   i_s0,     // Plain value for a mask operation
  input  msk_pkg::share_t   i_s1,
  input  msk_pkg::share_t   i_rand,
  output msk_pkg::share_t   o_r0,
  output msk_pkg::share_t   o_r1
);

  import msk_pkg::*;

  logic    load1;
  logic    in_bool;

  logic    v1_q;
  msk_op_t op_q;
  share_t  m0_q;    // Share 0 refreshed by the random word
  share_t  s1_q;
  share_t  rand_q;

  logic    st_bool;
  logic    st_mask;

  assign load1   = i_valid && (i_op inside {OP_BMASK, OP_AMASK, OP_BREMASK, OP_AREMASK});
  assign in_bool = (i_op == OP_BMASK) || (i_op == OP_BREMASK);

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      v1_q   <= 1'b0;
      op_q   <= OP_NOT;
      m0_q   <= '0;
      s1_q   <= '0;
      rand_q <= '0;
    end else begin
      v1_q <= load1;
      if (load1) begin
        op_q   <= i_op;
        m0_q   <= in_bool ? (i_s0 ^ i_rand) : (i_s0 + i_rand);
        s1_q   <= i_s1;    // Held back until share 0 is refreshed
        rand_q <= i_rand;
      end
    end
  end

  assign st_bool = (op_q == OP_BMASK) || (op_q == OP_BREMASK);
  assign st_mask = (op_q == OP_BMASK) || (op_q == OP_AMASK);

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      o_r0 <= '0;
      o_r1 <= '0;
    end else if (v1_q) begin
      o_r0 <= st_mask ? m0_q :
              st_bool ? (m0_q ^ s1_q) : (m0_q - s1_q);  // Old share 1 removed
      o_r1 <= rand_q;                                   // New share 1 is the mask
    end
  end

endmodule

// File: rtl/msk_pkg.sv
// Masked ALU types
`include "msk_defs.svh"

package msk_pkg;

  // One share of a two-share masked value
  typedef logic [`MSK_XLEN-1:0] share_t;

  // Operation codes
  typedef enum logic [3:0] {
    OP_NOT     = 4'd0,  // Boolean masked NOT of rs1
    OP_XOR     = 4'd1,  // Boolean masked XOR
    OP_AND     = 4'd2,  // Threshold AND
    OP_IOR     = 4'd3,  // OR built on the threshold AND
    OP_SRLI    = 4'd4,  // Shift right by immediate
    OP_SLLI    = 4'd5,  // Shift left by immediate
    OP_RORI    = 4'd6,  // Rotate right by immediate
    OP_BMASK   = 4'd7,  // Boolean mask of a plain value
    OP_AMASK   = 4'd8,  // Arithmetic mask of a plain value
    OP_BREMASK = 4'd9,  // Boolean remask of shares
    OP_AREMASK = 4'd10  // Arithmetic remask of shares
  } msk_op_t;

  // Codes 11 to 15 are unused and produce no result class

endpackage

// File: rtl/msk_prng.sv
// Mask refresh LFSR
`timescale 1ns/100ps
`include "msk_defs.svh"

module msk_prng (
  input  logic            g_clk,
  input  logic            g_resetn,
  input  logic            i_step,    // One step per accepted operation
  output msk_pkg::share_t o_rand
);

  import msk_pkg::*;

  share_t lfsr_q;
  logic   feedback;

  // XNOR feedback from taps 31, 21, 1 and 0
  assign feedback = ~(lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]);

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      lfsr_q <= `MSK_PRNG_SEED;
    end else if (i_step) begin
      lfsr_q <= {lfsr_q[`MSK_XLEN-2:0], feedback};  // Shift left, new bit enters at 0
    end
  end

  // Current state goes out, the step is seen by the next operation
  assign o_rand = lfsr_q;

endmodule

// File: rtl/msk_shift_rotate.sv
// Share barrel shifter
`timescale 1ns/100ps
`include "msk_defs.svh"

module msk_shift_rotate (
  input  msk_pkg::share_t          i_share,
  input  logic [`MSK_SHAMT_W-1:0]  i_shamt,
  input  msk_pkg::share_t          i_pad,    // Random padding, same for both shares
  input  msk_pkg::msk_op_t         i_op,
  output msk_pkg::share_t          o_share
);

  import msk_pkg::*;

  logic shl;
  logic rot;

  // Level outputs, lvl[0] is the input share
  wire share_t lvl [0:`MSK_SHAMT_W];

  assign shl = (i_op == OP_SLLI);
  assign rot = (i_op == OP_RORI);

  assign lvl[0] = i_share;

  // Level g moves the word by 2**g bits when shamt bit g is set
  for (genvar g = 0; g < `MSK_SHAMT_W; g++) begin : g_level
    localparam int W = 1 << g;
    localparam int P = W - 1;  // Pad slices 0, 2:1, 6:3, 14:7, 30:15

    logic [W-1:0] pad_bits;
    logic [W-1:0] fill_r;

    assign pad_bits = i_pad[P +: W];

    // Rotate brings the low bits round, shifts take fresh padding
    assign fill_r = rot ? lvl[g][W-1:0] : pad_bits;

    assign lvl[g+1] = !i_shamt[g] ? lvl[g] :
                      shl         ? {lvl[g][`MSK_XLEN-1-W:0], pad_bits} :
                                    {fill_r, lvl[g][`MSK_XLEN-1:W]};
  end

  // Equal padding in both shares drops out on recombination
  assign o_share = lvl[`MSK_SHAMT_W];

endmodule

// File: sim/tb_msk_alu.sv
// Masked ALU testbench
`timescale 1ns/100ps
`include "msk_defs.svh"

module tb_msk_alu;

  import msk_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int N_OPS      = 239;  // Operations issued over all tests

  typedef struct {
    share_t val;
    logic   arith;   // Recombine as s0 - s1
    logic   fresh;   // Share 1 must differ from the previous result
  } exp_t;

  logic                    g_clk = 1'b0;
  logic                    g_resetn;
  logic                    i_valid;
  msk_op_t                 i_op;
  share_t                  i_rs1_s0, i_rs1_s1, i_rs2_s0, i_rs2_s1;
  logic [`MSK_SHAMT_W-1:0] i_shamt;
  logic                    o_valid;
  share_t                  o_rd_s0, o_rd_s1;

  exp_t   exp_q [$];
  exp_t   ent;
  share_t cur_val = '0;     // Expected value of the result on the outputs
  logic   cur_arith = 1'b0;
  logic   cur_fresh = 1'b0;
  share_t prev_s1 = '0;
  share_t held_s1 = '0;
  int     errors = 0;
  int     tests_ok = 0;
  int     tests_bad = 0;
  int     issued = 0;

  msk_alu msk_alu_inst (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_valid  (i_valid),
    .i_op     (i_op),
    .i_rs1_s0 (i_rs1_s0),
    .i_rs1_s1 (i_rs1_s1),
    .i_rs2_s0 (i_rs2_s0),
    .i_rs2_s1 (i_rs2_s1),
    .i_shamt  (i_shamt),
    .o_valid  (o_valid),
    .o_rd_s0  (o_rd_s0),
    .o_rd_s1  (o_rd_s1)
  );

  always #(CLK_PERIOD / 2) g_clk = ~g_clk;

  function automatic share_t recombine(input share_t s0, input share_t s1, input logic arith);
    return arith ? (s0 - s1) : (s0 ^ s1);
  endfunction

  function automatic share_t logic_ref(input msk_op_t op, input share_t a, input share_t b);
    case (op)
      OP_NOT:  return ~a;
      OP_XOR:  return a ^ b;
      OP_AND:  return a & b;
      default: return a | b;
    endcase
  endfunction

  function automatic share_t shift_ref(input msk_op_t op, input share_t x, input int n);
    case (op)
      OP_SRLI: return x >> n;
      OP_SLLI: return x << n;
      default: return (x >> n) | (x << (`MSK_XLEN - n));  // n = 0 leaves x
    endcase
  endfunction

  // Outputs are stable here, pick the matching expected entry
  always @(negedge g_clk) begin
    if (g_resetn && o_valid) begin
      if (exp_q.size() == 0) begin
        $display("error at %0t: result came out with no operation in flight", $time);
        errors++;
      end else begin
        ent       = exp_q.pop_front();
        cur_val   = ent.val;
        cur_arith = ent.arith;
        cur_fresh = ent.fresh;
      end
      prev_s1 = held_s1;
      held_s1 = o_rd_s1;
    end
  end

  a_latency: assert property (@(posedge g_clk) disable iff (!g_resetn)
    i_valid |-> ##2 o_valid)
    else begin
      $display("error at %0t: o_valid missing two cycles after an accepted operation", $time);
      errors++;
    end

  a_no_spurious: assert property (@(posedge g_clk) disable iff (!g_resetn)
    o_valid |-> $past(i_valid, 2))
    else begin
      $display("error at %0t: o_valid high with no operation two cycles before", $time);
      errors++;
    end

  a_value: assert property (@(posedge g_clk) disable iff (!g_resetn)
    o_valid |-> recombine(o_rd_s0, o_rd_s1, cur_arith) == cur_val)
    else begin
      $display("error at %0t: o_rd_s0/o_rd_s1 recombined got %h, expected %h", $time,
               recombine($sampled(o_rd_s0), $sampled(o_rd_s1), $sampled(cur_arith)),
               $sampled(cur_val));
      errors++;
    end

  a_fresh: assert property (@(posedge g_clk) disable iff (!g_resetn)
    o_valid && cur_fresh |-> held_s1 != prev_s1)
    else begin
      $display("error at %0t: o_rd_s1 got %h, expected anything but %h", $time,
               $sampled(held_s1), $sampled(prev_s1));
      errors++;
    end

  task automatic issue(input msk_op_t op, input share_t a0, input share_t a1,
                       input share_t b0, input share_t b1, input int n,
                       input share_t expv, input logic arith, input logic fresh);
    exp_t e;
    @(posedge g_clk);
    i_valid  <= 1'b1;
    i_op     <= op;
    i_rs1_s0 <= a0;
    i_rs1_s1 <= a1;
    i_rs2_s0 <= b0;
    i_rs2_s1 <= b1;
    i_shamt  <= n[`MSK_SHAMT_W-1:0];
    e.val   = expv;
    e.arith = arith;
    e.fresh = fresh;
    exp_q.push_back(e);
    issued++;
  endtask

  // Plain operands split into Boolean shares with a random share 1
  task automatic issue_bool(input msk_op_t op, input share_t a, input share_t b,
                            input int n, input share_t expv);
    share_t a1;
    share_t b1;
    a1 = $urandom;
    b1 = $urandom;
    issue(op, a ^ a1, a1, b ^ b1, b1, n, expv, 1'b0, 1'b0);
  endtask

  task automatic drain();
    @(posedge g_clk);
    i_valid <= 1'b0;
    while (exp_q.size() != 0) @(posedge g_clk);
    repeat (2) @(posedge g_clk);  // Last checks fire here
  endtask

  task automatic end_test(input string name, input int err0);
    drain();
    if (errors == err0) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - err0);
    end
  endtask

  // Three cycles per operation, plus reset and drain slack
  initial begin
    #((N_OPS * 3 + 8 + 200) * CLK_PERIOD);
    $display("timeout: run stalled after %0d issued operations", issued);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    msk_op_t op;
    share_t  x;
    share_t  y;
    share_t  m;
    int      err0;
    void'($urandom(32'hc4e7_e76b));
    g_resetn = 1'b0;
    i_valid  = 1'b0;
    i_op     = OP_NOT;
    i_rs1_s0 = '0;
    i_rs1_s1 = '0;
    i_rs2_s0 = '0;
    i_rs2_s1 = '0;
    i_shamt  = '0;
    repeat (8) @(posedge g_clk);
    g_resetn <= 1'b1;
    repeat (4) @(posedge g_clk);  // Idle, o_valid has to stay low

    err0 = errors;
    x = $urandom;
    issue_bool(OP_NOT, x, '0, 0, ~x);
    drain();
    for (int i = 0; i < 6; i++) begin
      x = $urandom;
      y = $urandom;
      issue_bool(OP_XOR, x, y, 0, x ^ y);
    end
    end_test("latency and throughput", err0);

    err0 = errors;
    for (int i = 0; i < 40; i++) begin
      op = msk_op_t'($urandom_range(3, 0));  // NOT, XOR, AND or OR
      x = $urandom;
      y = $urandom;
      issue_bool(op, x, y, 0, logic_ref(op, x, y));
      if (i % 8 == 7) drain();
    end
    end_test("masked logic", err0);

    err0 = errors;
    for (int n = 0; n < `MSK_XLEN; n++) begin
      for (int k = 0; k < 3; k++) begin
        op = msk_op_t'(int'(OP_SRLI) + k);
        x = $urandom;
        issue_bool(op, x, '0, n, shift_ref(op, x, n));
      end
    end
    end_test("shifts and rotates", err0);

    err0 = errors;
    for (int i = 0; i < 20; i++) begin
      x = $urandom;
      issue(OP_BMASK, x, '0, '0, '0, 0, x, 1'b0, 1'b0);
      x = $urandom;
      issue_bool(OP_BREMASK, x, '0, 0, x);
    end
    end_test("boolean mask and remask", err0);

    err0 = errors;
    for (int i = 0; i < 20; i++) begin
      x = $urandom;
      issue(OP_AMASK, x, '0, '0, '0, 0, x, 1'b1, 1'b0);
      x = $urandom;
      m = $urandom;
      issue(OP_AREMASK, x + m, m, '0, '0, 0, x, 1'b1, 1'b0);
    end
    end_test("arithmetic mask and remask", err0);

    err0 = errors;
    for (int i = 0; i < 8; i++) begin
      x = $urandom;
      issue(OP_BMASK, x, '0, '0, '0, 0, x, 1'b0, 1'b0);
      issue(OP_BMASK, x, '0, '0, '0, 0, x, 1'b0, 1'b1);
    end
    end_test("fresh randomness", err0);

    $display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, errors);
    if (tests_bad == 0 && errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+rtl
rtl/msk_pkg.sv
rtl/msk_prng.sv
rtl/msk_shift_rotate.sv
rtl/msk_logic_ti.sv
rtl/msk_mask_unit.sv
rtl/msk_alu.sv
sim/tb_msk_alu.sv
